// File: bench/div_unit_tb.sv
`timescale 1ns/100ps
/*
 * Testbench for the AXI4-Lite divide unit at the package width of 32 bits.
 * Every wait is bounded, and the run stops at the first mismatch or timeout.
 * Operands come from an LFSR with a fixed seed, so every run is the same.
 */

module div_unit_tb import div_pkg::*; ();

    localparam int TIMEOUT  = 200;   // cycles allowed for any single wait.
    localparam int MAX_POLL = 100;   // STATUS reads before giving up.
    localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W - 1){1'b0}}};

    logic                  clk;
    logic                  rst_n;
    logic                  awvalid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awready;
    logic                  wvalid;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W/8-1:0]   wstrb;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  bready;
    logic                  arvalid;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    logic [DATA_W-1:0]     rdata;
    logic [1:0]            rresp;
    logic                  rready;
    logic [31:0]           lfsr_state;
    logic                  stall_on;   // random bready and rready hold-off.

    div_unit_top #(
        .DATA_W     (DATA_W),
        .AXI_ADDR_W (AXI_ADDR_W)
    ) uut (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awaddr (awaddr), .awready (awready),
        .wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wready (wready),
        .bvalid (bvalid), .bresp (bresp), .bready (bready),
        .arvalid (arvalid), .araddr (araddr), .arready (arready),
        .rvalid (rvalid), .rdata (rdata), .rresp (rresp), .rready (rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // failure reporting and random numbers -----------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t: %s expected 0x%h, got 0x%h",
                                $time, name, expected, actual));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit handed out.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Division rules: truncate toward zero, remainder follows the dividend.
    function automatic void ref_divide(input div_op_e op, input logic [DATA_W-1:0] a,
                                       input logic [DATA_W-1:0] b,
                                       output logic [DATA_W-1:0] q,
                                       output logic [DATA_W-1:0] r,
                                       output logic dz, output logic ovf);
        logic              a_neg;
        logic              b_neg;
        logic [DATA_W-1:0] a_mag;
        logic [DATA_W-1:0] b_mag;
        dz    = (b == '0);
        ovf   = (op == OP_DIVS) && (a == MOST_NEG) && (b == '1);
        a_neg = (op == OP_DIVS) && a[DATA_W-1];
        b_neg = (op == OP_DIVS) && b[DATA_W-1];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        if (dz) begin
            q = '0;   // results are cleared on a zero divisor.
            r = '0;
        end else begin
            q = (a_neg ^ b_neg) ? -(a_mag / b_mag) : (a_mag / b_mag);
            r = a_neg ? -(a_mag % b_mag) : (a_mag % b_mag);
        end
    endfunction

    // AXI4-Lite master tasks ---------------------------
    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb, output logic [1:0] resp);
        int waited;
        int stall;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("timeout: write address and data never accepted");
        end
        @(negedge clk);   // the handshake took place at the rising edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("timeout: no write response arrived");
        end
        stall = stall_on ? int'(random_bits(3)) : 0;
        repeat (stall) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
        int waited;
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        while (!arready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("timeout: read address never accepted");
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("timeout: no read data arrived");
        end
        stall = stall_on ? int'(random_bits(3)) : 0;
        repeat (stall) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] status;
        logic [1:0]        resp;
        int                polls;
        status = '0;
        polls  = 0;
        while (!status[1]) begin
            if (polls == MAX_POLL) abort_run("timeout: STATUS never showed done");
            axi_read(REG_STATUS, status, resp);
            polls++;
        end
    endtask

    // Full operation: operands, command, poll, then compare all results.
    task automatic run_divide(input div_op_e op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] exp_q;
        logic [DATA_W-1:0] exp_r;
        logic [DATA_W-1:0] data;
        logic              exp_dz;
        logic              exp_ovf;
        logic [1:0]        resp;
        ref_divide(op, a, b, exp_q, exp_r, exp_dz, exp_ovf);
        axi_write(REG_OPA, a, '1, resp);
        check_value("bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        axi_write(REG_OPB, b, '1, resp);
        check_value("bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        axi_write(REG_CTRL, DATA_W'(op), '1, resp);
        check_value("bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        wait_done();
        axi_read(REG_QUOT, data, resp);
        check_value("quot", exp_q, data);
        check_value("rresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        axi_read(REG_REM, data, resp);
        check_value("rem", exp_r, data);
        axi_read(REG_STATUS, data, resp);
        check_value("status", DATA_W'({exp_ovf, exp_dz, 2'b10}), data);
    endtask

    // an assertion in the bound checker ends the run here.
    always @(negedge clk) begin
        if (uut.u_seq.u_long_div.u_checker.fail_count != 0) begin
            abort_run("a divider timing assertion failed");
        end
    end

    // test sequence -------------------------------------
    initial begin
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp_q;
        logic [DATA_W-1:0] exp_r;
        logic              exp_dz;
        logic              exp_ovf;
        logic [1:0]        resp;

        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        stall_on   = 1'b0;
        lfsr_state = 32'd21338;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        $display("unsigned division");
        run_divide(OP_DIVU, '1, DATA_W'(1));
        run_divide(OP_DIVU, DATA_W'(5), DATA_W'(32'hFFFF_FFF0));
        run_divide(OP_DIVU, '1, '1);
        run_divide(OP_DIVU, DATA_W'(100), DATA_W'(7));
        repeat (10) begin
            a = random_bits(DATA_W);
            b = random_bits(DATA_W) >> random_bits(5);
            run_divide(OP_DIVU, a, b);
        end

        $display("signed division");
        run_divide(OP_DIVS, DATA_W'(100), DATA_W'(7));
        run_divide(OP_DIVS, DATA_W'(-100), DATA_W'(7));
        run_divide(OP_DIVS, DATA_W'(100), DATA_W'(-7));
        run_divide(OP_DIVS, DATA_W'(-100), DATA_W'(-7));
        repeat (8) begin
            a = random_bits(DATA_W);
            b = random_bits(DATA_W) >> random_bits(5);
            if (random_bits(1) != 0) begin
                b = -b;
            end
            run_divide(OP_DIVS, a, b);
        end

        $display("zero divisor and overflow");
        run_divide(OP_DIVU, DATA_W'(123), '0);
        run_divide(OP_DIVS, DATA_W'(-5), '0);
        run_divide(OP_DIVU, DATA_W'(1000), DATA_W'(10));
        run_divide(OP_DIVS, MOST_NEG, '1);
        run_divide(OP_DIVU, MOST_NEG, '1);

        $display("bus error and strobe rules");
        a = DATA_W'(-1000000);   // top bit set, so a signed run would give another result.
        b = DATA_W'(37);
        ref_divide(OP_DIVU, a, b, exp_q, exp_r, exp_dz, exp_ovf);
        axi_write(REG_OPA, a, '1, resp);
        axi_write(REG_OPB, b, '1, resp);
        axi_write(REG_CTRL, DATA_W'(OP_DIVU), '1, resp);
        check_value("bresp", DATA_W'(RESP_OKAY), DATA_W'(resp));
        axi_write(REG_CTRL, DATA_W'(OP_DIVS), '1, resp);   // still busy.
        check_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
        wait_done();
        axi_read(REG_QUOT, data, resp);
        check_value("quot", exp_q, data);
        axi_read(REG_REM, data, resp);
        check_value("rem", exp_r, data);

        axi_write(REG_CTRL, DATA_W'(0), '1, resp);
        check_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
        axi_write(REG_CTRL, DATA_W'(3), '1, resp);
        check_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
        axi_write(REG_STATUS, DATA_W'(1), '1, resp);
        check_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
        axi_write(AXI_ADDR_W'(8'h20), DATA_W'(1), '1, resp);
        check_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));
        axi_read(REG_STATUS, data, resp);
        check_value("status", DATA_W'(4'b0010), data);   // rejected commands left it done.
        axi_read(REG_QUOT, data, resp);
        check_value("quot", exp_q, data);
        axi_read(AXI_ADDR_W'(8'h18), data, resp);
        check_value("rdata", '0, data);
        check_value("rresp", DATA_W'(RESP_SLVERR), DATA_W'(resp));

        axi_write(REG_OPA, DATA_W'(32'h1122_3344), '1, resp);
        axi_write(REG_OPA, DATA_W'(32'hAABB_CCDD), 4'b0101, resp);
        axi_read(REG_OPA, data, resp);
        check_value("op_a", DATA_W'(32'h11BB_33DD), data);
        axi_write(REG_OPB, DATA_W'(32'h5566_7788), '1, resp);
        axi_write(REG_OPB, DATA_W'(32'hEEFF_0011), 4'b1010, resp);
        axi_read(REG_OPB, data, resp);
        check_value("op_b", DATA_W'(32'hEE66_0088), data);

        $display("response back-pressure");
        stall_on = 1'b1;
        repeat (8) begin
            a = random_bits(DATA_W);
            b = random_bits(DATA_W) >> random_bits(5);
            run_divide((random_bits(1) != 0) ? OP_DIVS : OP_DIVU, a, b);
        end

        if (uut.u_seq.u_long_div.u_checker.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "divider timing assertions failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: bench/long_div_checker.sv
`timescale 1ns/100ps
/*
 * Timing assertions for the divider core, bound into long_div. They assume
 * start is not repeated during a run, which the sequencer guarantees.
 */

module long_div_checker #(
    parameter int DATA_W = 32
) (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic ready,
    input logic working
);

    int unsigned fail_count = 0;   // read by the testbench monitor.

    // ready arrives exactly DATA_W cycles after start.
    start_to_ready: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> ##DATA_W ready
    ) else begin
        $error("ready did not follow start after %0d cycles", DATA_W);
        fail_count++;
    end

    ready_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ready |=> !ready
    ) else begin
        $error("ready stayed high for two cycles");
        fail_count++;
    end

    // a new start must not land in the middle of a run.
    start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !working
    ) else begin
        $error("start arrived while a division was running");
        fail_count++;
    end

endmodule

bind long_div long_div_checker #(
    .DATA_W (DATA_W)
) u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .ready   (ready),
    .working (working)
);

// File: rtl/div_axil_regs.sv
`timescale 1ns/100ps
/*
 * AXI4-Lite slave for the divide unit, one transaction per channel at a time.
 * Write address and write data must be presented together. CTRL is write
 * only and reads as zero. Operand writes are accepted while busy, since the
 * sequencer has already captured its operands.
 */

module div_axil_regs import div_pkg::*; #(
    parameter int DATA_W     = div_pkg::DATA_W,
    parameter int AXI_ADDR_W = div_pkg::AXI_ADDR_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // write channels
    input  logic                  awvalid,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    output logic                  awready,
    input  logic                  wvalid,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W/8-1:0]   wstrb,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,
    // read channels
    input  logic                  arvalid,
    input  logic [AXI_ADDR_W-1:0] araddr,
    output logic                  arready,
    output logic                  rvalid,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp,
    input  logic                  rready,
    // sequencer side
    output logic                  cmd_valid,
    output div_op_e               cmd_op,
    output logic [DATA_W-1:0]     op_a,
    output logic [DATA_W-1:0]     op_b,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  div_zero,
    input  logic                  overflow,
    input  logic [DATA_W-1:0]     quot,
    input  logic [DATA_W-1:0]     rem
);

    logic              wr_accept;
    logic              wr_fire;
    logic              wr_err;
    logic              legal_op;
    logic              ar_fire;
    logic              rvalid_next;
    logic [DATA_W-1:0] rd_data;
    logic              rd_err;

    // write path ------------------------------------
    // Both ready signals rise for one cycle once address and data are both
    // waiting and the previous response has been taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_accept <= 1'b0;
        end else begin
            wr_accept <= awvalid & wvalid & ~bvalid & ~wr_accept;
        end
    end

    assign awready  = wr_accept;
    assign wready   = wr_accept;
    assign wr_fire  = wr_accept & awvalid & wvalid;
    assign legal_op = (wdata[1:0] == OP_DIVU) || (wdata[1:0] == OP_DIVS);
    assign cmd_op   = div_op_e'(wdata[1:0]);

    always_comb begin
        cmd_valid = 1'b0;
        wr_err    = 1'b0;
        case (awaddr)
            AXI_ADDR_W'(REG_OPA),
            AXI_ADDR_W'(REG_OPB): wr_err = 1'b0;
            AXI_ADDR_W'(REG_CTRL): begin
                wr_err    = busy | ~legal_op;
                cmd_valid = wr_fire & ~busy & legal_op;   // same cycle as the handshake.
            end
            default: wr_err = 1'b1;   // read only or unmapped.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (wr_fire) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
                if (wstrb[i] && awaddr == AXI_ADDR_W'(REG_OPA)) begin
                    op_a[i*8 +: 8] <= wdata[i*8 +: 8];
                end
                if (wstrb[i] && awaddr == AXI_ADDR_W'(REG_OPB)) begin
                    op_b[i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // read path -------------------------------------
    assign ar_fire     = arvalid & arready;
    assign rvalid_next = ar_fire | (rvalid & ~rready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else begin
            rvalid  <= rvalid_next;
            arready <= ~rvalid_next;   // open again once the response is gone.
        end
    end

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (araddr)
            AXI_ADDR_W'(REG_OPA):    rd_data = op_a;
            AXI_ADDR_W'(REG_OPB):    rd_data = op_b;
            AXI_ADDR_W'(REG_CTRL):   rd_data = '0;
            AXI_ADDR_W'(REG_STATUS): rd_data[3:0] = {overflow, div_zero, done, busy};
            AXI_ADDR_W'(REG_QUOT):   rd_data = quot;
            AXI_ADDR_W'(REG_REM):    rd_data = rem;
            default:                 rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_data;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// File: rtl/div_pkg.sv
/*
 * Shared constants for the divide unit. Register offsets are byte addresses
 * and must stay word aligned. Command codes other than OP_DIVU and OP_DIVS
 * are rejected by the register block.
 */

package div_pkg;

    // widths ----------------------------------------
    localparam int DATA_W     = 32;   // operand and result width.
    localparam int AXI_ADDR_W = 8;

    // register map ----------------------------------
    localparam logic [AXI_ADDR_W-1:0] REG_OPA    = 8'h00; // dividend.
    localparam logic [AXI_ADDR_W-1:0] REG_OPB    = 8'h04; // divisor.
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h08; // command code, write launches.
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h0C; // busy, done, div_zero, overflow.
    localparam logic [AXI_ADDR_W-1:0] REG_QUOT   = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_REM    = 8'h14;

    // commands and responses ------------------------
    typedef enum logic [1:0] {
        OP_DIVU = 2'd1,
        OP_DIVS = 2'd2
    } div_op_e;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: rtl/div_sequencer.sv
`timescale 1ns/100ps
/*
 * Command sequencer for the divider core. cmd_valid is taken in any state,
 * so the caller must not pulse it while busy. A zero divisor finishes in one
 * cycle with zero results; signed overflow runs and keeps the core result.
 */

module div_sequencer import div_pkg::*; #(
    parameter int DATA_W = div_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  div_op_e           cmd_op,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    output logic              busy,
    output logic              done,
    output logic              div_zero,
    output logic              overflow,
    output logic [DATA_W-1:0] quot,
    output logic [DATA_W-1:0] rem
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } state_e;

    state_e            state;
    logic              signed_op;
    logic              b_zero;
    logic              ovf_case;
    logic [DATA_W:0]   core_a;
    logic [DATA_W:0]   core_b;
    logic              core_start;
    logic              core_ready;
    logic [DATA_W-1:0] core_quot;
    logic [DATA_W-1:0] core_rem;

    assign signed_op = (cmd_op == OP_DIVS);
    assign b_zero    = (op_b == '0);
    // most negative value by minus one does not fit in DATA_W bits.
    assign ovf_case  = signed_op && (op_a == {1'b1, {(DATA_W - 1){1'b0}}}) && (&op_b);

    // operand capture -------------------------------
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            core_a <= {signed_op & op_a[DATA_W-1], op_a};
            core_b <= {signed_op & op_b[DATA_W-1], op_b};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_start <= 1'b0;
        end else begin
            core_start <= cmd_valid & ~b_zero;   // the core never sees a zero divisor.
        end
    end

    // state and results -----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_zero <= 1'b0;
            overflow <= 1'b0;
            quot     <= '0;
            rem      <= '0;
        end else if (cmd_valid) begin
            div_zero <= b_zero;
            overflow <= ovf_case;
            if (b_zero) begin
                state <= FINISH;
                quot  <= '0;
                rem   <= '0;
            end else begin
                state <= RUN;
            end
        end else if (state == RUN && core_ready) begin
            state <= FINISH;
            quot  <= core_quot;
            rem   <= core_rem;
        end
    end

    assign busy = (state == RUN);
    assign done = (state == FINISH);   // held until the next command.

    long_div #(
        .DATA_W (DATA_W)
    ) u_long_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (core_start),
        .dividend  (core_a),
        .divisor   (core_b),
        .ready     (core_ready),
        .quotient  (core_quot),
        .remainder (core_rem)
    );

endmodule

// File: rtl/div_unit_top.sv
`timescale 1ns/100ps
/*
 * Memory-mapped divide unit with an AXI4-Lite slave port. Data width is
 * DATA_W, with 16 and 32 supported; wstrb carries DATA_W/8 bits.
 */

module div_unit_top import div_pkg::*; #(
    parameter int DATA_W     = div_pkg::DATA_W,
    parameter int AXI_ADDR_W = div_pkg::AXI_ADDR_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    output logic                  awready,
    input  logic                  wvalid,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [DATA_W/8-1:0]   wstrb,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,
    input  logic                  arvalid,
    input  logic [AXI_ADDR_W-1:0] araddr,
    output logic                  arready,
    output logic                  rvalid,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp,
    input  logic                  rready
);

    logic              cmd_valid;
    div_op_e           cmd_op;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic              busy;
    logic              done;
    logic              div_zero;
    logic              overflow;
    logic [DATA_W-1:0] quot;
    logic [DATA_W-1:0] rem;

    div_axil_regs #(
        .DATA_W     (DATA_W),
        .AXI_ADDR_W (AXI_ADDR_W)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rready    (rready),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .op_a      (op_a),
        .op_b      (op_b),
        .busy      (busy),
        .done      (done),
        .div_zero  (div_zero),
        .overflow  (overflow),
        .quot      (quot),
        .rem       (rem)
    );

    div_sequencer #(
        .DATA_W (DATA_W)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .op_a      (op_a),
        .op_b      (op_b),
        .busy      (busy),
        .done      (done),
        .div_zero  (div_zero),
        .overflow  (overflow),
        .quot      (quot),
        .rem       (rem)
    );

endmodule

// File: rtl/long_div.sv
`timescale 1ns/100ps
/*
 * Restoring divider, one quotient bit per clock. Operands arrive sign
 * extended to DATA_W+1 bits. ready pulses exactly DATA_W cycles after start,
 * and a new start restarts the count. A zero divisor is not detected here.
 */

module long_div #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [DATA_W:0]   dividend,
    input  logic [DATA_W:0]   divisor,
    output logic              ready,
    output logic [DATA_W-1:0] quotient,
    output logic [DATA_W-1:0] remainder
);

    localparam int CNT_W = $clog2(DATA_W + 1);

    logic [CNT_W-1:0]    count;
    logic                working;
    logic [DATA_W:0]     dividend_mag;
    logic [DATA_W:0]     divisor_mag;
    logic [DATA_W-1:0]   part_rem;    // running partial remainder.
    logic [2*DATA_W-1:0] shift_div;   // divisor, moved right one place per step.
    logic [DATA_W-1:0]   part_quot;
    logic [2*DATA_W:0]   diff;
    logic                fits;
    logic [DATA_W-1:0]   quot_mag;
    logic [DATA_W-1:0]   rem_mag;
    logic                quot_neg;
    logic                rem_neg;

    assign dividend_mag = dividend[DATA_W] ? -dividend : dividend;
    assign divisor_mag  = divisor[DATA_W] ? -divisor : divisor;

    // trial subtraction -------------------------------
    assign diff    = {{(DATA_W + 1){1'b0}}, part_rem} - {1'b0, shift_div};
    assign fits    = ~diff[2*DATA_W];   // no borrow, so the divisor fits.
    assign working = (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(DATA_W);
        end else if (working) begin
            count <= count - 1'b1;
        end
    end

    // Operand and quotient registers carry no reset, start loads them.
    always_ff @(posedge clk) begin
        if (start) begin
            part_rem  <= dividend_mag[DATA_W-1:0];
            shift_div <= {1'b0, divisor_mag[DATA_W-1:0], {(DATA_W - 1){1'b0}}};
            part_quot <= '0;
            quot_neg  <= dividend[DATA_W] ^ divisor[DATA_W];
            rem_neg   <= dividend[DATA_W];
        end else if (working) begin
            if (fits) begin
                part_rem <= diff[DATA_W-1:0];
            end
            shift_div <= shift_div >> 1;
            part_quot <= {part_quot[DATA_W-2:0], fits};
        end
    end

    // The last step is taken straight from the subtractor so that the
    // result is ready in the same cycle as the pulse.
    assign quot_mag = {part_quot[DATA_W-2:0], fits};
    assign rem_mag  = fits ? diff[DATA_W-1:0] : part_rem;

    assign ready     = (count == CNT_W'(1));
    assign quotient  = quot_neg ? -quot_mag : quot_mag;
    assign remainder = rem_neg ? -rem_mag : rem_mag;   // sign of the dividend.

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the divide unit testbench with Verilator and run it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module div_unit_tb -Mdir obj_dir -f sim.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vdiv_unit_tb +verilator+error+limit+100
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
else
    echo "simulation finished with status 0"
fi
exit "$sim_status"

// File: sim.f
rtl/div_pkg.sv
rtl/long_div.sv
rtl/div_sequencer.sv
rtl/div_axil_regs.sv
rtl/div_unit_top.sv
bench/long_div_checker.sv
bench/div_unit_tb.sv
